// File: hdl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire rv_pkg::ctrl_t ctrl,
    input  wire rv_pkg::xlen_t pc,
    input  wire rv_pkg::xlen_t rdata1,
    input  wire rv_pkg::xlen_t rdata2,
    input  wire rv_pkg::xlen_t imm_i,
    input  wire rv_pkg::xlen_t imm_s,
    input  wire rv_pkg::xlen_t imm_u,
    output rv_pkg::xlen_t      result,
    output logic               branch_taken
);
    import rv_pkg::*;

    xlen_t op1, op2, raw;
    logic [5:0] shamt;
    logic eq, lt_s, lt_u, lt;

    assign op1 = ({64{ctrl.sel_alusrc1[0]}} & rdata1)
               | ({64{ctrl.sel_alusrc1[1]}} & pc);     // lui leaves op1 at zero
    assign op2 = ({64{ctrl.sel_alusrc2[0]}} & rdata2)
               | ({64{ctrl.sel_alusrc2[1]}} & imm_i)
               | ({64{ctrl.sel_alusrc2[2]}} & imm_u)
               | ({64{ctrl.sel_alusrc2[3]}} & 64'd4)
               | ({64{ctrl.sel_alusrc2[4]}} & imm_s);

    assign shamt = op2[5:0];
    assign eq    = (op1 == op2);
    assign lt_s  = ($signed(op1) < $signed(op2));
    assign lt_u  = (op1 < op2);

    always_comb begin
        raw = '0;
        if (ctrl.alu_op[0])  raw = op1 + op2;
        if (ctrl.alu_op[1])  raw = op1 - op2;
        if (ctrl.alu_op[2])  raw = {63'd0, lt_s};
        if (ctrl.alu_op[3])  raw = {63'd0, lt_u};
        if (ctrl.alu_op[4])  raw = op1 & op2;
        if (ctrl.alu_op[5])  raw = op1 | op2;
        if (ctrl.alu_op[6])  raw = op1 ^ op2;
        if (ctrl.alu_op[7])  raw = op1 << shamt;
        if (ctrl.alu_op[8])  raw = op1 >> shamt;
        if (ctrl.alu_op[9])  raw = xlen_t'($signed(op1) >>> shamt);
        if (ctrl.alu_op[10]) raw = op2;  // lui pass
    end

    // addw and addiw keep only the low word
    assign result = ctrl.sel_alures[1] ? {{32{raw[31]}}, raw[31:0]} : raw;

    assign lt = ctrl.alu_op[3] ? lt_u : lt_s;  // bltu/bgeu ride on sltu

    assign branch_taken = (ctrl.sel_nextpc[3] & eq)
                        | (ctrl.sel_nextpc[4] & ~eq)
                        | (ctrl.sel_nextpc[5] & lt)
                        | (ctrl.sel_nextpc[6] & ~lt);

endmodule

`default_nettype wire

// File: hdl/controlunit.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_consts.svh"

module controlunit (
    input  wire logic [6:0] opcode,
    input  wire logic [2:0] funct3,
    input  wire logic [6:0] funct7,
    output rv_pkg::ctrl_t   ctrl,
    output logic            inv
);
    logic is_addi, is_sltiu, is_andi, is_slli, is_srai, is_addiw;
    logic is_lui, is_auipc, is_jal, is_jalr;
    logic is_add, is_sub, is_and, is_or, is_xor, is_slt, is_sltu;
    logic is_sll, is_srl, is_sra, is_addw;
    logic is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu;
    logic is_ld, is_lw, is_lh, is_lb, is_lwu, is_lhu, is_lbu;
    logic is_sd, is_sw, is_sh, is_sb;
    logic f7_zero, f7_alt, imm_type, r_type, b_type, load, store, word_op;

    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    assign is_addi  = (opcode == `OP_IMM) && (funct3 == 3'b000);
    assign is_sltiu = (opcode == `OP_IMM) && (funct3 == 3'b011);
    assign is_andi  = (opcode == `OP_IMM) && (funct3 == 3'b111);
    // six-bit shamt, funct7[0] belongs to it
    assign is_slli  = (opcode == `OP_IMM) && (funct3 == 3'b001) && (funct7[6:1] == 6'b000000);
    assign is_srai  = (opcode == `OP_IMM) && (funct3 == 3'b101) && (funct7[6:1] == 6'b010000);
    assign is_addiw = (opcode == `OP_IMM32) && (funct3 == 3'b000);

    assign is_lui   = (opcode == `OP_LUI);
    assign is_auipc = (opcode == `OP_AUIPC);
    assign is_jal   = (opcode == `OP_JAL);
    assign is_jalr  = (opcode == `OP_JALR) && (funct3 == 3'b000);

    assign is_add  = (opcode == `OP_REG) && (funct3 == 3'b000) && f7_zero;
    assign is_sub  = (opcode == `OP_REG) && (funct3 == 3'b000) && f7_alt;
    assign is_sll  = (opcode == `OP_REG) && (funct3 == 3'b001) && f7_zero;
    assign is_slt  = (opcode == `OP_REG) && (funct3 == 3'b010) && f7_zero;
    assign is_sltu = (opcode == `OP_REG) && (funct3 == 3'b011) && f7_zero;
    assign is_xor  = (opcode == `OP_REG) && (funct3 == 3'b100) && f7_zero;
    assign is_srl  = (opcode == `OP_REG) && (funct3 == 3'b101) && f7_zero;
    assign is_sra  = (opcode == `OP_REG) && (funct3 == 3'b101) && f7_alt;
    assign is_or   = (opcode == `OP_REG) && (funct3 == 3'b110) && f7_zero;
    assign is_and  = (opcode == `OP_REG) && (funct3 == 3'b111) && f7_zero;
    assign is_addw = (opcode == `OP_REG32) && (funct3 == 3'b000) && f7_zero;

    assign is_beq  = (opcode == `OP_BRANCH) && (funct3 == 3'b000);
    assign is_bne  = (opcode == `OP_BRANCH) && (funct3 == 3'b001);
    assign is_blt  = (opcode == `OP_BRANCH) && (funct3 == 3'b100);
    assign is_bge  = (opcode == `OP_BRANCH) && (funct3 == 3'b101);
    assign is_bltu = (opcode == `OP_BRANCH) && (funct3 == 3'b110);
    assign is_bgeu = (opcode == `OP_BRANCH) && (funct3 == 3'b111);

    assign is_lb  = (opcode == `OP_LOAD) && (funct3 == 3'b000);
    assign is_lh  = (opcode == `OP_LOAD) && (funct3 == 3'b001);
    assign is_lw  = (opcode == `OP_LOAD) && (funct3 == 3'b010);
    assign is_ld  = (opcode == `OP_LOAD) && (funct3 == 3'b011);
    assign is_lbu = (opcode == `OP_LOAD) && (funct3 == 3'b100);
    assign is_lhu = (opcode == `OP_LOAD) && (funct3 == 3'b101);
    assign is_lwu = (opcode == `OP_LOAD) && (funct3 == 3'b110);

    assign is_sb = (opcode == `OP_STORE) && (funct3 == 3'b000);
    assign is_sh = (opcode == `OP_STORE) && (funct3 == 3'b001);
    assign is_sw = (opcode == `OP_STORE) && (funct3 == 3'b010);
    assign is_sd = (opcode == `OP_STORE) && (funct3 == 3'b011);

    assign imm_type = is_addi | is_sltiu | is_andi | is_slli | is_srai | is_addiw;
    assign r_type   = is_add | is_sub | is_and | is_or | is_xor | is_slt | is_sltu
                    | is_sll | is_srl | is_sra | is_addw;
    assign b_type   = is_beq | is_bne | is_blt | is_bge | is_bltu | is_bgeu;
    assign load     = is_ld | is_lw | is_lh | is_lb | is_lwu | is_lhu | is_lbu;
    assign store    = is_sd | is_sw | is_sh | is_sb;
    assign word_op  = is_addw | is_addiw;

    assign inv = ~(imm_type | r_type | b_type | load | store
                 | is_lui | is_auipc | is_jal | is_jalr);

    assign ctrl.alu_op = {is_lui,
                          is_sra | is_srai,
                          is_srl,
                          is_sll | is_slli,
                          is_xor,
                          is_or,
                          is_and | is_andi,
                          is_sltu | is_sltiu | is_bltu | is_bgeu,
                          is_slt | is_blt | is_bge,
                          is_sub | is_beq | is_bne,
                          is_add | is_addi | is_addw | is_addiw | is_auipc
                          | is_jal | is_jalr | load | store};
    assign ctrl.rf_we       = imm_type | r_type | load | is_lui | is_auipc | is_jal | is_jalr;
    assign ctrl.sel_alusrc1 = {is_auipc | is_jal | is_jalr,
                               imm_type | r_type | b_type | load | store};
    assign ctrl.sel_alusrc2 = {store,
                               is_jal | is_jalr,  // return address
                               is_auipc | is_lui,
                               imm_type | load,
                               r_type | b_type};
    assign ctrl.sel_nextpc  = {is_bge | is_bgeu,
                               is_blt | is_bltu,
                               is_bne,
                               is_beq,
                               is_jalr,
                               is_jal,
                               imm_type | r_type | load | store | is_lui | is_auipc};
    assign ctrl.sel_rfres   = {is_lwu | is_lhu | is_lbu, is_ld | is_lw | is_lh | is_lb, ~load};
    assign ctrl.mem_ena     = load | store;
    assign ctrl.mem_wen     = store;
    assign ctrl.mem_mask    = {is_lb | is_lbu | is_sb,
                               is_lh | is_lhu | is_sh,
                               is_lw | is_lwu | is_sw,
                               is_ld | is_sd};
    assign ctrl.sel_alures  = {word_op, ~word_op};

    always_comb begin
        if (!inv) begin
            assert final ($onehot(ctrl.alu_op) && $onehot(ctrl.sel_nextpc))
                else $error("decoded selects not one-hot");
        end
    end

endmodule

`default_nettype wire

// File: hdl/core_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_consts.svh"

module core_top (
    input  wire logic          clk,
    input  wire logic          reset,
    output rv_pkg::xlen_t      imem_addr,
    input  wire rv_pkg::inst_t imem_data,
    output logic               retire_valid,
    output rv_pkg::retire_t    retire,
    output logic               halted
);
    import rv_pkg::*;

    xlen_t pc_q, pc_next, jalr_sum;
    core_state_e state_q;
    ctrl_t ctrl, ctrl_exec;
    logic inv, exec_ok, branch_taken;
    xlen_t imm_i, imm_s, imm_b, imm_u, imm_j;
    xlen_t rdata1, rdata2, result, load_data, wb_data;
    reg_addr_t rd;

    assign imem_addr = pc_q;
    assign rd        = imem_data[11:7];

    controlunit u_controlunit (
        .opcode (imem_data[6:0]),
        .funct3 (imem_data[14:12]),
        .funct7 (imem_data[31:25]),
        .ctrl   (ctrl),
        .inv    (inv)
    );

    immgen u_immgen (
        .inst  (imem_data),
        .imm_i (imm_i),
        .imm_s (imm_s),
        .imm_b (imm_b),
        .imm_u (imm_u),
        .imm_j (imm_j)
    );

    // nothing commits unless running and the word decoded
    assign exec_ok = (state_q == core_run) && !inv && !reset;

    always_comb begin
        ctrl_exec         = ctrl;
        ctrl_exec.rf_we   = ctrl.rf_we & exec_ok;
        ctrl_exec.mem_wen = ctrl.mem_wen & exec_ok;
    end

    regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .rs1    (imem_data[19:15]),
        .rs2    (imem_data[24:20]),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (ctrl_exec.rf_we),
        .rd     (rd),
        .wdata  (wb_data)
    );

    alu u_alu (
        .ctrl         (ctrl),
        .pc           (pc_q),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .imm_i        (imm_i),
        .imm_s        (imm_s),
        .imm_u        (imm_u),
        .result       (result),
        .branch_taken (branch_taken)
    );

    lsu u_lsu (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl_exec),
        .addr      (result),
        .wdata     (rdata2),
        .load_data (load_data)
    );

    assign wb_data  = ctrl.sel_rfres[0] ? result : load_data;
    assign jalr_sum = rdata1 + imm_i;

    always_comb begin
        pc_next = pc_q + 64'd4;
        if (ctrl.sel_nextpc[1]) begin
            pc_next = pc_q + imm_j;
        end else if (ctrl.sel_nextpc[2]) begin
            pc_next = {jalr_sum[63:1], 1'b0};
        end else if (branch_taken) begin
            pc_next = pc_q + imm_b;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q    <= `RESET_PC;
            state_q <= core_run;
        end else begin
            if (exec_ok) pc_q <= pc_next;
            if ((state_q == core_run) && inv) state_q <= core_halt;  // stuck until reset
        end
    end

    assign halted       = (state_q == core_halt);
    assign retire_valid = exec_ok;

    always_comb begin
        retire.pc        = pc_q;
        retire.inst      = imem_data;
        retire.rd        = rd;
        retire.rd_we     = ctrl.rf_we;
        retire.rd_data   = wb_data;
        retire.mem_we    = ctrl.mem_wen;
        retire.mem_addr  = result;
        retire.mem_wdata = rdata2;
    end

    a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
        halted |-> !retire_valid ##1 halted)
        else $error("core retired or left halt");

endmodule

`default_nettype wire

// File: hdl/immgen.sv
`timescale 1ns/1ns
`default_nettype none

module immgen (
    input  wire rv_pkg::inst_t inst,
    output rv_pkg::xlen_t      imm_i,
    output rv_pkg::xlen_t      imm_s,
    output rv_pkg::xlen_t      imm_b,
    output rv_pkg::xlen_t      imm_u,
    output rv_pkg::xlen_t      imm_j
);
    logic sign;

    assign sign = inst[31];

    assign imm_i = {{52{sign}}, inst[31:20]};
    assign imm_s = {{52{sign}}, inst[31:25], inst[11:7]};
    assign imm_b = {{51{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{32{sign}}, inst[31:12], 12'h000};  // sign-extended on rv64
    assign imm_j = {{43{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

endmodule

`default_nettype wire

// File: hdl/lsu.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_consts.svh"

module lsu (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire rv_pkg::ctrl_t ctrl,
    input  wire rv_pkg::xlen_t addr,
    input  wire rv_pkg::xlen_t wdata,
    output rv_pkg::xlen_t      load_data
);
    import rv_pkg::*;

    logic [7:0] mem [`DMEM_BYTES];
    logic [`DMEM_AW-1:0] idx [8];
    logic [3:0] nbytes;
    xlen_t raw;
    logic sx;

    // each byte wraps on its own
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            idx[i] = addr[`DMEM_AW-1:0] + i[`DMEM_AW-1:0];
        end
    end

    always_comb begin
        nbytes = 4'd0;
        if (ctrl.mem_mask[0]) nbytes = 4'd8;
        if (ctrl.mem_mask[1]) nbytes = 4'd4;
        if (ctrl.mem_mask[2]) nbytes = 4'd2;
        if (ctrl.mem_mask[3]) nbytes = 4'd1;
    end

    always_comb begin
        raw = '0;
        for (int i = 0; i < 8; i++) begin
            if (i < nbytes) raw[8*i +: 8] = mem[idx[i]];
        end
    end

    assign sx = ctrl.sel_rfres[1];  // signed load

    always_comb begin
        load_data = raw;  // ld
        if (ctrl.mem_mask[1]) load_data = {{32{sx & raw[31]}}, raw[31:0]};
        if (ctrl.mem_mask[2]) load_data = {{48{sx & raw[15]}}, raw[15:0]};
        if (ctrl.mem_mask[3]) load_data = {{56{sx & raw[7]}}, raw[7:0]};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_BYTES; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (ctrl.mem_ena && ctrl.mem_wen) begin
            for (int i = 0; i < 8; i++) begin
                if (i < nbytes) mem[idx[i]] <= wdata[8*i +: 8];
            end
        end
    end

    a_mask_onehot: assert property (@(posedge clk) disable iff (reset)
        ctrl.mem_ena |-> $onehot(ctrl.mem_mask))
        else $error("memory access with bad size mask");

endmodule

`default_nettype wire

// File: hdl/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire rv_pkg::reg_addr_t rs1,
    input  wire rv_pkg::reg_addr_t rs2,
    output rv_pkg::xlen_t          rdata1,
    output rv_pkg::xlen_t          rdata2,
    input  wire logic              we,
    input  wire rv_pkg::reg_addr_t rd,
    input  wire rv_pkg::xlen_t     wdata
);
    import rv_pkg::*;

    xlen_t regs [1:31];  // no storage for x0

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: hdl/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// first fetch address after reset
`define RESET_PC 64'h0

// data memory inside the load/store unit
`define DMEM_BYTES 256
`define DMEM_AW 8

// major opcodes
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_IMM    7'b0010011
`define OP_IMM32  7'b0011011
`define OP_REG    7'b0110011
`define OP_REG32  7'b0111011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111

`endif

// File: hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    // one-hot, bit 0 up: add sub slt sltu and or xor sll srl sra lui
    typedef logic [10:0] alu_op_t;

    // one-hot, bit 0 up: double word half byte
    typedef logic [3:0]  mem_mask_t;

    typedef struct packed {
        alu_op_t    alu_op;
        logic       rf_we;
        logic [1:0] sel_alusrc1;  // pc, rdata1
        logic [4:0] sel_alusrc2;  // imm_s, 4, imm_u, imm_i, rdata2
        logic [6:0] sel_nextpc;   // bge, blt, bne, beq, jalr, jal, pc+4
        logic [2:0] sel_rfres;    // unsigned load, signed load, alu
        logic       mem_ena;
        logic       mem_wen;
        mem_mask_t  mem_mask;
        logic [1:0] sel_alures;   // word result, full result
    } ctrl_t;

    // one entry per retired instruction
    typedef struct packed {
        xlen_t     pc;
        inst_t     inst;
        reg_addr_t rd;
        logic      rd_we;
        xlen_t     rd_data;
        logic      mem_we;
        xlen_t     mem_addr;
        xlen_t     mem_wdata;
    } retire_t;

    typedef enum logic {
        core_run,
        core_halt
    } core_state_e;

endpackage

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/controlunit.sv
hdl/immgen.sv
hdl/regfile.sv
hdl/alu.sv
hdl/lsu.sv
hdl/core_top.sv
test/core_tb.sv

// File: test/core_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_consts.svh"

module core_tb;
    import rv_pkg::*;

    localparam int PROG_LEN  = 200;
    localparam int JUMP_SPAN = 12;  // furthest forward jump in slots
    localparam int TIMEOUT   = 5000;

    logic    clk;
    logic    reset;
    xlen_t   imem_addr;
    inst_t   imem_data;
    logic    retire_valid;
    retire_t retire;
    logic    halted;

    inst_t      prog [PROG_LEN];
    int         kind [PROG_LEN];  // 0 plain, 1 branch, 2 jal, 3 jalr base, 4 jalr, 5 end
    retire_t    expected [$];
    xlen_t      mregs [32];
    logic [7:0] mmem [`DMEM_BYTES];
    xlen_t      mpc;
    int         total;
    int         retired;
    int         cycles;
    logic       saw_invalid;

    core_top UUT (
        .clk          (clk),
        .reset        (reset),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .retire_valid (retire_valid),
        .retire       (retire),
        .halted       (halted)
    );

    // slots past the program read as zero and never decode
    assign imem_data = (imem_addr < 4 * PROG_LEN) ? prog[imem_addr[9:2]] : 32'h0;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic inst_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};  // R-type too with {funct7, rs2} as imm
    endfunction

    function automatic inst_t random_plain();
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic [11:0] imm;
        int k;
        rd  = 5'($urandom);
        rs1 = 5'($urandom);
        rs2 = 5'($urandom);
        imm = 12'($urandom);
        k   = $urandom % 12;
        case (k)
            0: return enc_i(imm, rs1, 3'b000, rd, `OP_IMM);
            1: return enc_i(imm, rs1, 3'b011, rd, `OP_IMM);
            2: return enc_i(imm, rs1, 3'b111, rd, `OP_IMM);
            3: return enc_i({6'b000000, imm[5:0]}, rs1, 3'b001, rd, `OP_IMM);
            4: return enc_i({6'b010000, imm[5:0]}, rs1, 3'b101, rd, `OP_IMM);
            5: return enc_i(imm, rs1, 3'b000, rd, `OP_IMM32);
            6: return {20'($urandom), rd, `OP_LUI};
            7: return {20'($urandom), rd, `OP_AUIPC};
            8: return enc_i(imm, ($urandom % 2) ? 5'd0 : rs1, 3'($urandom % 7), rd, `OP_LOAD);
            9: return {imm[11:5], rs2, ($urandom % 2) ? 5'd0 : rs1, 3'($urandom % 4),
                       imm[4:0], `OP_STORE};
            default: begin
                k = $urandom % 11;
                if (k == 8) return enc_i({7'h20, rs2}, rs1, 3'b000, rd, `OP_REG);  // sub
                if (k == 9) return enc_i({7'h20, rs2}, rs1, 3'b101, rd, `OP_REG);  // sra
                if (k == 10) return enc_i({7'h00, rs2}, rs1, 3'b000, rd, `OP_REG32);
                return enc_i({7'h00, rs2}, rs1, 3'(k), rd, `OP_REG);
            end
        endcase
    endfunction

    task automatic build_program();
        int i;
        int t;
        int bk;
        reg_addr_t base;
        i = 0;
        while (i < PROG_LEN - 1) begin
            t = $urandom % 16;
            if (t == 0 && i < PROG_LEN - 2) begin
                kind[i]     = 3;
                kind[i + 1] = 4;
                i += 2;
            end else begin
                kind[i] = (t < 3) ? 1 : ((t == 3) ? 2 : 0);
                i += 1;
            end
        end
        kind[PROG_LEN - 1] = 5;
        base = 5'd1;
        for (i = 0; i < PROG_LEN; i++) begin
            // forward only and never onto the jalr half of a pair
            t = ((kind[i] == 3) ? i + 2 : i + 1) + int'($urandom % JUMP_SPAN);
            if (t > PROG_LEN - 1) t = PROG_LEN - 1;
            if (kind[t] == 4) t = t - 1;
            bk = $urandom % 6;
            case (kind[i])
                0: prog[i] = random_plain();
                1: begin
                    bk = (bk < 2) ? bk : bk + 2;
                    t  = (t - i) * 4;
                    prog[i] = {t[12], t[10:5], 5'($urandom), 5'($urandom), 3'(bk),
                               t[4:1], t[11], `OP_BRANCH};
                end
                2: begin
                    t = (t - i) * 4;
                    prog[i] = {t[20], t[10:1], t[11], t[19:12], 5'($urandom), `OP_JAL};
                end
                3: begin
                    base    = 5'(1 + $urandom % 31);
                    prog[i] = enc_i(12'(t * 4 + 1), 5'd0, 3'b000, base, `OP_IMM);  // odd base
                end
                4: prog[i] = enc_i(12'h000, base, 3'b000, 5'($urandom), `OP_JALR);
                default: prog[i] = 32'h0;
            endcase
        end
    endtask

    task automatic model_step(input inst_t w, output retire_t e, output logic bad);
        xlen_t a;
        xlen_t b;
        xlen_t ii;
        xlen_t res;
        xlen_t nxt;
        xlen_t addr;
        logic [2:0] f3;
        logic [9:0] f7f3;
        logic take;
        int n;
        a    = mregs[w[19:15]];
        b    = mregs[w[24:20]];
        ii   = {{52{w[31]}}, w[31:20]};
        f3   = w[14:12];
        f7f3 = {w[31:25], f3};
        e    = '0;
        e.pc    = mpc;
        e.inst  = w;
        e.rd    = w[11:7];
        e.rd_we = 1'b1;
        nxt  = mpc + 4;
        res  = '0;
        take = 1'b0;
        bad  = 1'b0;
        n    = 1 << f3[1:0];
        case (w[6:0])
            `OP_IMM: begin
                if (f3 == 3'b000) res = a + ii;
                else if (f3 == 3'b011) res = (a < ii) ? 64'd1 : 64'd0;
                else if (f3 == 3'b111) res = a & ii;
                else if (f3 == 3'b001 && w[31:26] == 6'b000000) res = a << w[25:20];
                else if (f3 == 3'b101 && w[31:26] == 6'b010000) res = $signed(a) >>> w[25:20];
                else bad = 1'b1;
            end
            `OP_IMM32, `OP_REG32: begin
                res = a + ((w[6:0] == `OP_IMM32) ? ii : b);
                res = {{32{res[31]}}, res[31:0]};
                bad = (w[6:0] == `OP_IMM32) ? (f3 != 3'b000) : (f7f3 != 10'h000);
            end
            `OP_REG: begin
                case (f7f3)
                    10'h000: res = a + b;
                    10'h100: res = a - b;
                    10'h001: res = a << b[5:0];
                    10'h002: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                    10'h003: res = (a < b) ? 64'd1 : 64'd0;
                    10'h004: res = a ^ b;
                    10'h005: res = a >> b[5:0];
                    10'h105: res = $signed(a) >>> b[5:0];
                    10'h006: res = a | b;
                    10'h007: res = a & b;
                    default: bad = 1'b1;
                endcase
            end
            `OP_LUI: res = {{32{w[31]}}, w[31:12], 12'h000};
            `OP_AUIPC: res = mpc + {{32{w[31]}}, w[31:12], 12'h000};
            `OP_JAL: begin
                res = mpc + 4;
                nxt = mpc + {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            `OP_JALR: begin
                res = mpc + 4;
                nxt = (a + ii) & ~64'd1;
                bad = (f3 != 3'b000);
            end
            `OP_BRANCH: begin
                e.rd_we = 1'b0;
                case (f3)
                    3'b000: take = (a == b);
                    3'b001: take = (a != b);
                    3'b100: take = ($signed(a) < $signed(b));
                    3'b101: take = ($signed(a) >= $signed(b));
                    3'b110: take = (a < b);
                    3'b111: take = (a >= b);
                    default: bad = 1'b1;
                endcase
                if (take) nxt = mpc + {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            `OP_LOAD: begin
                addr = a + ii;
                for (int k = 0; k < n; k++)
                    res[8*k +: 8] = mmem[(addr + k) % `DMEM_BYTES];  // each byte wraps
                if (!f3[2] && n == 1) res = {{56{res[7]}}, res[7:0]};
                if (!f3[2] && n == 2) res = {{48{res[15]}}, res[15:0]};
                if (!f3[2] && n == 4) res = {{32{res[31]}}, res[31:0]};
                bad = (f3 == 3'b111);
            end
            `OP_STORE: begin
                e.rd_we     = 1'b0;
                addr        = a + {{52{w[31]}}, w[31:25], w[11:7]};
                bad         = f3[2];
                e.mem_we    = 1'b1;
                e.mem_addr  = addr;
                e.mem_wdata = b;
                for (int k = 0; k < n; k++)
                    if (!bad) mmem[(addr + k) % `DMEM_BYTES] = b[8*k +: 8];
            end
            default: bad = 1'b1;
        endcase
        if (!bad) begin
            if (e.rd_we && e.rd != 5'd0) mregs[e.rd] = res;
            e.rd_data = res;
            mpc = nxt;
        end
    endtask

    task automatic run_model();
        retire_t e;
        inst_t w;
        logic bad;
        mpc = `RESET_PC;
        for (int r = 0; r < 32; r++)
            mregs[r] = '0;
        for (int m = 0; m < `DMEM_BYTES; m++)
            mmem[m] = 8'h00;
        bad = 1'b0;
        while (!bad && expected.size() < TIMEOUT) begin
            w = (mpc < 4 * PROG_LEN) ? prog[mpc[9:2]] : 32'h0;
            model_step(w, e, bad);
            if (!bad) expected.push_back(e);
        end
        total = expected.size();
    endtask

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(string what, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic compare_retire();
        retire_t e;
        if (expected.size() == 0) fail_run("The core retired more instructions than the model ran");
        e = expected.pop_front();
        retired++;
        check_value("imem_addr", imem_addr, e.pc);
        check_value("pc", retire.pc, e.pc);
        check_value("inst", retire.inst, e.inst);
        check_value("rd_we", retire.rd_we, e.rd_we);
        check_value("mem_we", retire.mem_we, e.mem_we);
        if (e.rd_we) begin
            check_value("rd", retire.rd, e.rd);
            check_value("rd_data", retire.rd_data, e.rd_data);
        end
        if (e.mem_we) begin
            check_value("mem_addr", retire.mem_addr, e.mem_addr);
            check_value("mem_wdata", retire.mem_wdata, e.mem_wdata);
        end
    endtask

    // outputs still hold the pre-edge values here
    always @(posedge clk) begin
        if (!reset) begin
            if (saw_invalid) begin
                check_value("halted", halted, 1'b1);
                check_value("retire_valid while halted", retire_valid, 1'b0);
            end else if (retire_valid) begin
                compare_retire();
            end else begin
                check_value("halted before the invalid word", halted, 1'b0);
                check_value("retirements still pending", expected.size(), 0);
                saw_invalid = 1'b1;
            end
        end
    end

    initial begin
        reset       = 1'b1;
        saw_invalid = 1'b0;
        retired     = 0;
        void'($urandom(32'h5165));
        build_program();
        run_model();
        repeat (4) @(negedge clk);
        reset  = 1'b0;
        cycles = 0;
        while (!halted && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            fail_run("Timeout: the core never halted within 5000 cycles");
        end else begin
            repeat (5) @(negedge clk);  // halt has to stick
            check_value("retirement count", retired, total);
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire
